// ==== sources.f ====
+incdir+source
source/l2_bus_pkg.sv
source/l2_mem_pkg.sv
source/l2_bank_arbiter.sv
source/l2_sram_bank.sv
source/l2_interconnect.sv
source/l2_subsystem.sv
verif/l2_subsystem_sva.sv
verif/l2_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run of the L2 subsystem testbench

VERILATOR ?= verilator
TOP       ?= l2_subsystem_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0

FILELIST  := sources.f
SOURCES   := $(shell grep -v '^+' $(FILELIST)) source/l2_consts.svh
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/l2_subsystem_tb.sv ====
// Testbench for the L2 subsystem
// Clock and reset, LFSR-driven traffic on all six ports
// Word-level memory model with byte-enable merging
// Read data checks and cross-group alias checks

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_subsystem_tb;

  import l2_bus_pkg::*;

  localparam int unsigned NP          = `L2_NB_PORTS;
  localparam int unsigned WORDS       = `L2_NB_BANKS * `L2_BANK_WORDS;
  localparam int unsigned HOT_WORDS   = 16;   // Small set so banks collide
  localparam int unsigned RAND_CYCLES = 400;
  localparam int unsigned TIMEOUT     = 100;

  logic          clk;
  logic          rst_n;
  l2_req_t       port_req [NP];
  logic [NP-1:0] port_gnt;
  l2_rsp_t       port_rsp [NP];

  logic [15:0]   lfsr_q = 16'd61;
  logic [31:0]   model [WORDS];      // Expected contents by window word
  logic [NP-1:0] pend_rd;            // Read granted at the last edge
  logic [31:0]   pend_exp [NP];
  int unsigned   reads_checked;

  l2_subsystem u_l2_subsystem (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .port_req_i (port_req),
    .port_gnt_o (port_gnt),
    .port_rsp_o (port_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] group_base(input int unsigned p);
    return (p < `L2_NB_AXI_PORTS) ? `L2_AXI_BASE : `L2_UDMA_BASE;
  endfunction

  // Window word reached by a port with wrap outside the L2
  function automatic int unsigned word_index(input int unsigned p, input logic [31:0] addr);
    logic [31:0] off;
    off = addr - group_base(p);
    return (off >> 2) % WORDS;
  endfunction

  function automatic l2_req_t random_request(input int unsigned p);
    l2_req_t     r;
    logic [31:0] woff;
    logic [31:0] wrap;
    r.req   = (rand_bits(2) != 0);
    r.we    = (rand_bits(1) != 0);
    woff    = rand_bits($clog2(HOT_WORDS));
    wrap    = rand_bits(1);        // Alias one window above
    r.addr  = group_base(p) + (woff << 2) + (wrap << 12);
    r.be    = 4'(rand_bits(4));
    r.wdata = rand_bits(32);
    return r;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  // One full-word access on one port with rdata sampled on the response cycle
  task automatic single_access(input int unsigned p, input logic [31:0] addr, input logic we,
                               input logic [31:0] wdata, output logic [31:0] rdata);
    l2_req_t     r;
    int unsigned t;
    r       = '0;
    r.req   = 1'b1;
    r.addr  = addr;
    r.we    = we;
    r.be    = '1;
    r.wdata = wdata;
    @(posedge clk);
    port_req[p] <= r;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) begin
        abort_run($sformatf("Timeout: port %0d never granted at %0t", p, $time));
      end
    end while (!port_gnt[p]);
    port_req[p] <= '0;
    @(posedge clk);
    rdata = port_rsp[p].rdata;
  endtask

  // Model update and read checks at each grant edge
  always @(posedge clk) begin
    int unsigned idx;
    if (rst_n) begin
      if (u_l2_subsystem.u_sva.fail_cnt != 0) begin
        abort_run($sformatf("Bound assertion failed before %0t", $time));
      end
      for (int unsigned p = 0; p < NP; p++) begin
        if (pend_rd[p]) begin
          assert (port_rsp[p].valid && (port_rsp[p].rdata == pend_exp[p])) else
            abort_run($sformatf("FAILED %0t: port %0d read %h, expected %h",
                                $time, p, port_rsp[p].rdata, pend_exp[p]));
          reads_checked++;
        end
        pend_rd[p] = 1'b0;
        if (port_gnt[p]) begin
          idx = word_index(p, port_req[p].addr);
          if (port_req[p].we) begin
            for (int unsigned l = 0; l < 4; l++) begin
              if (port_req[p].be[l]) begin
                model[idx][8*l +: 8] = port_req[p].wdata[8*l +: 8];
              end
            end
          end else begin
            pend_rd[p]  = 1'b1;
            pend_exp[p] = model[idx];
          end
        end
      end
    end
  end

  initial begin
    logic [31:0] rd;
    int unsigned t;
    logic        busy;
    rst_n         <= 1'b0;
    pend_rd       = '0;
    reads_checked = 0;
    for (int unsigned p = 0; p < NP; p++) begin
      port_req[p] <= '0;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Fill the hot set through both groups
    for (int unsigned w = 0; w < HOT_WORDS; w++) begin
      single_access(w % NP, group_base(w % NP) + 4 * w, 1'b1, rand_bits(32), rd);
    end

    // Bridge write then uDMA read of the same word, and the reverse
    single_access(2, `L2_AXI_BASE + 32'h24, 1'b1, 32'hA5C3_0F96, rd);
    single_access(5, `L2_UDMA_BASE + 32'h24, 1'b0, 32'h0, rd);
    assert (rd == 32'hA5C3_0F96) else
      abort_run($sformatf("FAILED %0t: uDMA alias read %h, expected a5c30f96", $time, rd));
    single_access(4, `L2_UDMA_BASE + 32'h18, 1'b1, 32'h3C96_5AF0, rd);
    single_access(0, `L2_AXI_BASE + 32'h18, 1'b0, 32'h0, rd);
    assert (rd == 32'h3C96_5AF0) else
      abort_run($sformatf("FAILED %0t: bridge alias read %h, expected 3c965af0", $time, rd));

    // Random traffic with each request held until its grant
    for (int unsigned c = 0; c < RAND_CYCLES; c++) begin
      @(posedge clk);
      for (int unsigned p = 0; p < NP; p++) begin
        if (!(port_req[p].req && !port_gnt[p])) begin
          port_req[p] <= random_request(p);
        end
      end
    end

    t    = 0;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int unsigned p = 0; p < NP; p++) begin
        if (port_gnt[p]) begin
          port_req[p] <= '0;
        end else if (port_req[p].req) begin
          busy = 1'b1;
        end
      end
      t++;
      if (t > TIMEOUT) begin
        abort_run("Timeout: ports still requesting after the traffic phase");
      end
    end
    repeat (2) @(posedge clk);  // Last responses land

    if (reads_checked == 0) begin
      abort_run("No read response was checked during the run");
    end else if (u_l2_subsystem.u_sva.fail_cnt != 0) begin
      abort_run($sformatf("Bound assertions failed %0d times", u_l2_subsystem.u_sva.fail_cnt));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// ==== verif/l2_subsystem_sva.sv ====
// Bound checks on the L2 subsystem ports
// Response valid timing against the grant
// Per-bank grant exclusivity from rebased addresses
// Round-robin wait bound for a held request

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_subsystem_sva (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  l2_bus_pkg::l2_req_t    port_req_i [`L2_NB_PORTS],
  input  logic [`L2_NB_PORTS-1:0] port_gnt_i,
  input  l2_bus_pkg::l2_rsp_t    port_rsp_i [`L2_NB_PORTS]
);

  localparam int unsigned NP = `L2_NB_PORTS;
  localparam int unsigned NB = `L2_NB_BANKS;
  localparam int unsigned BW = $clog2(`L2_NB_BANKS);

  logic [NB-1:0][NP-1:0] want;  // Requesting ports per bank
  logic [NB-1:0][NP-1:0] won;   // Granted ports per bank
  int unsigned           fail_cnt = 0;

  always_comb begin
    logic [31:0] off;
    want = '0;
    won  = '0;
    for (int unsigned p = 0; p < NP; p++) begin
      off = port_req_i[p].addr - ((p < `L2_NB_AXI_PORTS) ? `L2_AXI_BASE : `L2_UDMA_BASE);
      want[off[2 +: BW]][p] = port_req_i[p].req;
      won[off[2 +: BW]][p]  = port_gnt_i[p];
    end
  end

  for (genvar b = 0; b < NB; b++) begin : g_bank
    // Exactly one winner among the requesters, none when idle
    a_bank_one_winner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ((won[b] & ~want[b]) == '0) && ((|want[b]) ? $onehot(won[b]) : 1'b1))
      else begin
        $error("bank %0d grant vector %b for requests %b", b, won[b], want[b]);
        fail_cnt = fail_cnt + 1;
      end
  end

  for (genvar p = 0; p < NP; p++) begin : g_port
    logic [3:0] wait_q;  // Cycles lost in arbitration

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        wait_q <= '0;
      end else if (port_req_i[p].req && !port_gnt_i[p]) begin
        wait_q <= wait_q + 1'b1;
      end else begin
        wait_q <= '0;
      end
    end

    a_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      port_gnt_i[p] |=> port_rsp_i[p].valid)
      else begin
        $error("port %0d granted without a response on the next cycle", p);
        fail_cnt = fail_cnt + 1;
      end

    a_rsp_only_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      port_rsp_i[p].valid |-> $past(port_gnt_i[p]))
      else begin
        $error("port %0d response valid without a grant one cycle before", p);
        fail_cnt = fail_cnt + 1;
      end

    a_fair_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wait_q < NP)
      else begin
        $error("port %0d waited %0d cycles for a grant", p, wait_q);
        fail_cnt = fail_cnt + 1;
      end
  end

endmodule

bind l2_subsystem l2_subsystem_sva u_sva (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .port_req_i (port_req_i),
  .port_gnt_i (port_gnt_o),
  .port_rsp_i (port_rsp_o)
);

// ==== source/l2_subsystem.sv ====
// L2 scratchpad top level
// Six request ports over four interleaved SRAM banks

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_subsystem (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  l2_bus_pkg::l2_req_t        port_req_i [`L2_NB_PORTS],
  output logic [`L2_NB_PORTS-1:0]    port_gnt_o,
  output l2_bus_pkg::l2_rsp_t        port_rsp_o [`L2_NB_PORTS]
);

  import l2_mem_pkg::*;

  bank_req_t                  bank_req   [`L2_NB_BANKS];
  logic [`L2_DATA_WIDTH-1:0]  bank_rdata [`L2_NB_BANKS];

  l2_interconnect u_interconnect (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .port_req_i   (port_req_i),
    .port_gnt_o   (port_gnt_o),
    .port_rsp_o   (port_rsp_o),
    .bank_req_o   (bank_req),
    .bank_rdata_i (bank_rdata)
  );

  // Banks never stall, every request is served
  for (genvar b = 0; b < `L2_NB_BANKS; b++) begin : g_bank
    l2_sram_bank u_bank (
      .clk_i      (clk_i),
      .bank_req_i (bank_req[b]),
      .rdata_o    (bank_rdata[b])
    );
  end

endmodule

// ==== source/l2_interconnect.sv ====
// L2 logarithmic interconnect
// Per-port rebasing and bank decode
// One round-robin arbiter per bank
// Registered response routing with one cycle latency

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_interconnect (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  l2_bus_pkg::l2_req_t        port_req_i [`L2_NB_PORTS],
  output logic [`L2_NB_PORTS-1:0]    port_gnt_o,
  output l2_bus_pkg::l2_rsp_t        port_rsp_o [`L2_NB_PORTS],
  output l2_mem_pkg::bank_req_t      bank_req_o [`L2_NB_BANKS],
  input  logic [`L2_DATA_WIDTH-1:0]  bank_rdata_i [`L2_NB_BANKS]
);

  import l2_mem_pkg::*;

  localparam int unsigned NP     = `L2_NB_PORTS;
  localparam int unsigned NB     = `L2_NB_BANKS;
  localparam int unsigned BANK_W = $bits(bank_idx_t);
  localparam int unsigned ROW_W  = $bits(bank_row_t);

  logic [31:0]               port_addr [NP];  // Address inside the L2 window
  bank_idx_t                 port_bank [NP];
  bank_row_t                 port_row  [NP];

  logic [NB-1:0][NP-1:0]     bank_port_req;
  logic [NB-1:0][NP-1:0]     bank_gnt;
  port_idx_t                 bank_win [NB];

  logic [NB-1:0]             rsp_vld_q;       // Bank served someone last cycle
  port_idx_t                 rsp_port_q [NB];

  // Each group subtracts its own base, word index then splits bank/row
  for (genvar p = 0; p < NP; p++) begin : g_port
    localparam logic [31:0] BASE = (p < `L2_NB_AXI_PORTS) ? `L2_AXI_BASE : `L2_UDMA_BASE;
    assign port_addr[p] = port_req_i[p].addr - BASE;
    assign port_bank[p] = port_addr[p][2 +: BANK_W];
    assign port_row[p]  = port_addr[p][2 + BANK_W +: ROW_W];
  end

  always_comb begin
    for (int unsigned b = 0; b < NB; b++) begin
      for (int unsigned p = 0; p < NP; p++) begin
        bank_port_req[b][p] = port_req_i[p].req && (port_bank[p] == bank_idx_t'(b));
      end
    end
  end

  for (genvar b = 0; b < NB; b++) begin : g_arb
    l2_bank_arbiter u_arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (bank_port_req[b]),
      .gnt_o   (bank_gnt[b]),
      .win_o   (bank_win[b])
    );
  end

  // Winner fields to the bank, grants back to the ports
  always_comb begin
    port_gnt_o = '0;
    for (int unsigned b = 0; b < NB; b++) begin
      bank_req_o[b].req   = |bank_gnt[b];
      bank_req_o[b].row   = port_row[bank_win[b]];
      bank_req_o[b].we    = port_req_i[bank_win[b]].we;
      bank_req_o[b].be    = port_req_i[bank_win[b]].be;
      bank_req_o[b].wdata = port_req_i[bank_win[b]].wdata;
      port_gnt_o          = port_gnt_o | bank_gnt[b];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_vld_q <= '0;
    end else begin
      for (int unsigned b = 0; b < NB; b++) begin
        rsp_vld_q[b] <= |bank_gnt[b];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned b = 0; b < NB; b++) begin
      rsp_port_q[b] <= bank_win[b];
    end
  end

  // A port wins at most one bank per cycle, so at most one match
  always_comb begin
    for (int unsigned p = 0; p < NP; p++) begin
      port_rsp_o[p] = '0;
      for (int unsigned b = 0; b < NB; b++) begin
        if (rsp_vld_q[b] && (rsp_port_q[b] == port_idx_t'(p))) begin
          port_rsp_o[p].valid = 1'b1;
          port_rsp_o[p].rdata = bank_rdata_i[b];
        end
      end
    end
  end

endmodule

// ==== source/l2_sram_bank.sv ====
// Single-port L2 SRAM bank
// Byte-lane writes under the byte enables
// Registered read data, one cycle after the request

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_sram_bank (
  input  logic                        clk_i,
  input  l2_mem_pkg::bank_req_t       bank_req_i,
  output logic [`L2_DATA_WIDTH-1:0]   rdata_o
);

  localparam int unsigned LANES = `L2_BE_WIDTH;

  logic [`L2_DATA_WIDTH-1:0] mem_q [`L2_BANK_WORDS];

  // Write lands at the request edge
  always_ff @(posedge clk_i) begin
    if (bank_req_i.req && bank_req_i.we) begin
      for (int unsigned l = 0; l < LANES; l++) begin
        if (bank_req_i.be[l]) begin
          mem_q[bank_req_i.row][8*l +: 8] <= bank_req_i.wdata[8*l +: 8];
        end
      end
    end
  end

  // Output register holds the last word read
  always_ff @(posedge clk_i) begin
    if (bank_req_i.req && !bank_req_i.we) begin
      rdata_o <= mem_q[bank_req_i.row];
    end
  end

endmodule

// ==== source/l2_bank_arbiter.sv ====
// Round-robin arbiter for one L2 bank
// Combinational grant, pointer moves one past the winner

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_bank_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [`L2_NB_PORTS-1:0]      req_i,
  output logic [`L2_NB_PORTS-1:0]      gnt_o,
  output l2_mem_pkg::port_idx_t        win_o
);

  import l2_mem_pkg::*;

  localparam int unsigned NP = `L2_NB_PORTS;

  port_idx_t ptr_q;      // Highest priority port this cycle
  logic      any_req;

  assign any_req = |req_i;

  // First requester at or after the pointer, wrapping at NP
  always_comb begin
    int unsigned idx;
    logic        found;
    gnt_o = '0;
    win_o = ptr_q;
    found = 1'b0;
    for (int unsigned k = 0; k < NP; k++) begin
      idx = int'(ptr_q) + k;
      if (idx >= NP) begin
        idx = idx - NP;
      end
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        gnt_o[idx] = 1'b1;
        win_o      = port_idx_t'(idx);
      end
    end
  end

  // A grant is given whenever anyone requests
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (any_req) begin
      if (win_o == port_idx_t'(NP - 1)) begin
        ptr_q <= '0;  // Wrap past the last port
      end else begin
        ptr_q <= win_o + 1'b1;
      end
    end
  end

endmodule

// ==== source/l2_mem_pkg.sv ====
// Bank-side types of the L2 subsystem
// Bank, row and port index types and the bank request

`include "l2_consts.svh"

package l2_mem_pkg;

  typedef logic [$clog2(`L2_NB_BANKS)-1:0]   bank_idx_t;
  typedef logic [$clog2(`L2_BANK_WORDS)-1:0] bank_row_t;
  typedef logic [$clog2(`L2_NB_PORTS)-1:0]   port_idx_t;

  // Access presented to one SRAM bank, always accepted
  typedef struct packed {
    logic                        req;
    bank_row_t                   row;
    logic                        we;
    logic [`L2_BE_WIDTH-1:0]     be;
    logic [`L2_DATA_WIDTH-1:0]   wdata;
  } bank_req_t;

endpackage

// ==== source/l2_bus_pkg.sv ====
// Port-side bus types of the L2 subsystem
// l2_req_t  request presented by a bridge or uDMA port
// l2_rsp_t  response returned one cycle after the grant

`include "l2_consts.svh"

package l2_bus_pkg;

  // One port request, held until granted
  typedef struct packed {
    logic                        req;
    logic [31:0]                 addr;   // Global byte address
    logic                        we;     // 1 for write
    logic [`L2_BE_WIDTH-1:0]     be;
    logic [`L2_DATA_WIDTH-1:0]   wdata;
  } l2_req_t;

  // One port response
  typedef struct packed {
    logic                        valid;  // Single-cycle pulse
    logic [`L2_DATA_WIDTH-1:0]   rdata;
  } l2_rsp_t;

endpackage

// ==== source/l2_consts.svh ====
// L2 scratchpad sizing constants
// Port counts for the bridge and uDMA groups
// Bank count, bank depth and data width
// Global base addresses seen by each port group

`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// Request ports
`define L2_NB_AXI_PORTS   4
`define L2_NB_UDMA_PORTS  2
`define L2_NB_PORTS       (`L2_NB_AXI_PORTS + `L2_NB_UDMA_PORTS)

// Banks, word interleaved
`define L2_NB_BANKS       4
`define L2_BANK_WORDS     256  // Simulation depth

// Data path
`define L2_DATA_WIDTH     32
`define L2_BE_WIDTH       (`L2_DATA_WIDTH / 8)

// Where each group sees the L2 in its own map
`define L2_AXI_BASE       32'h7800_0000
`define L2_UDMA_BASE      32'h1C00_0000

`endif
